/* verif/bomb_grid_testdata.txt */
# name rst wait p1_set p1_pos p1_len p2_set p2_pos p2_len probe code p1_unb p2_unb result
# len is blast length minus one, result is over*4 + p1_win*2 + p2_win, a placing line waits >= 1
place_p1          0 1 1 68  1 0 200 0 68  1 1 0 0
refuse_occupied   0 1 1 68  1 0 200 0 68  1 1 0 0
fuse_running      0 4 0 135 0 0 200 0 68  1 1 0 0
cross_center      0 0 0 135 0 0 200 0 68  2 0 0 0
cross_up          0 0 0 135 0 0 200 0 36  3 0 0 0
cross_down        0 0 0 135 0 0 200 0 100 4 0 0 0
cross_left        0 0 0 135 0 0 200 0 66  5 0 0 0
water_dry_center  0 0 0 135 0 0 200 0 68  0 0 0 0
water_dry_arm     0 0 0 135 0 0 200 0 100 0 0 0 0
# corner bomb, arms clipped at the top and left edges
corner_place      0 1 0 135 0 1 0   3 0   1 0 1 0
corner_burst      0 7 0 135 0 0 200 0 0   2 0 0 0
corner_right      0 0 0 135 0 0 200 0 4   6 0 0 0
corner_down       0 0 0 135 0 0 200 0 64  4 0 0 0
corner_clip       0 0 0 135 0 0 200 0 255 0 0 0 0
# capacity and tie, then p2 steps into an arm
tie_p1_wins       0 1 1 150 0 1 150 0 150 1 1 0 0
cap_second        0 1 1 10  0 0 200 0 10  1 2 0 0
cap_refused       0 1 1 12  0 0 200 0 12  0 2 0 0
arm_soak          0 3 0 12  0 0 151 0 151 6 1 0 0
arm_result        0 0 0 12  0 0 151 0 150 2 1 0 6
# fresh game, both players in one cross
draw_place        1 1 1 100 1 0 132 0 100 1 1 0 0
draw_result       0 8 0 68  0 0 132 0 68  3 0 0 7
late_request      0 1 1 40  0 0 132 0 40  0 0 0 7
late_idle         0 3 0 40  0 0 132 0 100 0 0 0 7

/* build.f */
verilog/bomb_grid_pkg.sv
verilog/placement_ctrl.sv
verilog/cell_array.sv
verilog/blast_spread.sv
verilog/board_report.sv
verilog/bomb_grid_top.sv
verif/bomb_grid_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= bomb_grid_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

PASS_MSG := *** TEST PASSED ***
FAIL_MSG := *** TEST FAILED ***
SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/bomb_grid_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bomb_grid_tb
	import bomb_grid_pkg::*;
();

	localparam string DATA_FILE = "verif/bomb_grid_testdata.txt";
	localparam int FIELD_NUM = 14; // name plus 13 numbers
	localparam int RST_CYCLES = 4;
	localparam int TIMEOUT_MARGIN = 20;

	// one line of the data file, numeric part
	typedef struct packed {
		logic rst;
		logic [15:0] wait_cyc;
		player_req_t p1;
		player_req_t p2;
		cell_idx_t probe;
		logic [3:0] exp_code;
		logic [2:0] exp_p1;
		logic [2:0] exp_p2;
		logic [2:0] exp_res; // over, p1_win, p2_win
	} vec_t;

	logic clk;
	logic rst_n;
	player_req_t p1_req;
	player_req_t p2_req;
	occ_code_t [CELL_NUM-1:0] occ_grid;
	logic [2:0] p1_unburst;
	logic [2:0] p2_unburst;
	game_result_t result;

	vec_t vecs[$];
	string names[$];
	int err_cnt;
	int check_cnt;
	int cycle_cnt;
	int cycle_limit;

	bomb_grid_top #(
		.FUSE_CYCLES(8),
		.WATER_CYCLES(4),
		.BOMB_CAP(2)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.p1_req(p1_req),
		.p2_req(p2_req),
		.occ_grid(occ_grid),
		.p1_unburst(p1_unburst),
		.p2_unburst(p2_unburst),
		.result(result)
	);

	always #10 clk = ~clk; // 20 ns period

	// run guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_value(input string test, input string what, input int exp_val,
		input int act_val);
		check_cnt++;
		if (exp_val != act_val) begin
			err_cnt++;
			$display("ERROR %s %s: expected %0d, actual %0d", test, what, exp_val, act_val);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		string name;
		int f[FIELD_NUM-1];
		vec_t v;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test data file %s", DATA_FILE);
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
			if (n <= 0)
				continue; // blank line
			if (n != FIELD_NUM) begin
				$display("malformed line in the test data file: %s", line);
				err_cnt++;
				continue;
			end
			v.rst = (f[0] != 0);
			v.wait_cyc = 16'(f[1]);
			v.p1.set = (f[2] != 0);
			v.p1.pos = CELL_W'(f[3]);
			v.p1.len = 2'(f[4]);
			v.p2.set = (f[5] != 0);
			v.p2.pos = CELL_W'(f[6]);
			v.p2.len = 2'(f[7]);
			v.probe = CELL_W'(f[8]);
			v.exp_code = 4'(f[9]);
			v.exp_p1 = 3'(f[10]);
			v.exp_p2 = 3'(f[11]);
			v.exp_res = 3'(f[12]);
			vecs.push_back(v);
			names.push_back(name);
		end
		$fclose(fd);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// drive at one edge, request taken at the next, check wait_cyc edges after driving
	task automatic run_vector(input string name, input vec_t v);
		if (v.rst)
			reset_dut();
		@(posedge clk);
		p1_req <= v.p1;
		p2_req <= v.p2;
		for (int k = 0; k < int'(v.wait_cyc); k++) begin
			@(posedge clk);
			p1_req.set <= 1'b0; // strobe lasts one cycle
			p2_req.set <= 1'b0;
		end
		@(negedge clk);
		check_value(name, "probe code", int'(v.exp_code), int'(occ_grid[v.probe]));
		check_value(name, "p1 unburst", int'(v.exp_p1), int'(p1_unburst));
		check_value(name, "p2 unburst", int'(v.exp_p2), int'(p2_unburst));
		check_value(name, "result", int'(v.exp_res), int'(result));
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		p1_req = '0;
		p2_req = '0;
		err_cnt = 0;
		check_cnt = 0;
		cycle_cnt = 0;
		load_vectors();
		if (vecs.size() == 0) begin
			$display("no test lines were read from the test data file");
			err_cnt++;
		end
		cycle_limit = RST_CYCLES + TIMEOUT_MARGIN;
		foreach (vecs[i]) begin
			cycle_limit += 1 + int'(vecs[i].wait_cyc);
			if (vecs[i].rst)
				cycle_limit += RST_CYCLES + 1;
		end
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		foreach (vecs[i])
			run_vector(names[i], vecs[i]);
		$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/bomb_grid_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bomb_grid_top
	import bomb_grid_pkg::*;
#(
	parameter int FUSE_CYCLES = 60,
	parameter int WATER_CYCLES = 20,
	parameter int BOMB_CAP = 1 // at most 7
) (
	input wire logic clk,
	input wire logic rst_n,
	input player_req_t p1_req,
	input player_req_t p2_req,
	output occ_code_t [CELL_NUM-1:0] occ_grid,
	output logic [2:0] p1_unburst,
	output logic [2:0] p2_unburst,
	output game_result_t result
);

	logic accept1;
	logic accept2;
	logic [1:0] burst_owner1;
	logic [1:0] burst_owner2;
	cell_t [CELL_NUM-1:0] cells;
	wet_map_t wet_map;
	dir_t [CELL_NUM-1:0] wet_dir;

	placement_ctrl #(
		.BOMB_CAP(BOMB_CAP)
	) i_placement_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.p1_req(p1_req),
		.p2_req(p2_req),
		.cells(cells),
		.result(result),
		.burst_owner1(burst_owner1),
		.burst_owner2(burst_owner2),
		.accept1(accept1),
		.accept2(accept2),
		.p1_unburst(p1_unburst),
		.p2_unburst(p2_unburst)
	);

	cell_array #(
		.FUSE_CYCLES(FUSE_CYCLES),
		.WATER_CYCLES(WATER_CYCLES)
	) i_cell_array (
		.clk(clk),
		.rst_n(rst_n),
		.p1_req(p1_req),
		.p2_req(p2_req),
		.accept1(accept1),
		.accept2(accept2),
		.wet_map(wet_map),
		.wet_dir(wet_dir),
		.cells(cells),
		.burst_owner1(burst_owner1),
		.burst_owner2(burst_owner2)
	);

	blast_spread #(
		.FUSE_CYCLES(FUSE_CYCLES)
	) i_blast_spread (
		.cells(cells),
		.wet_map(wet_map),
		.wet_dir(wet_dir)
	);

	board_report i_board_report (
		.clk(clk),
		.rst_n(rst_n),
		.cells(cells),
		.p1_cor(p1_req.pos),
		.p2_cor(p2_req.pos),
		.occ_grid(occ_grid),
		.result(result)
	);

endmodule

`default_nettype wire

/* verilog/board_report.sv */
`timescale 1ns/100ps
`default_nettype none

module board_report
	import bomb_grid_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input cell_t [CELL_NUM-1:0] cells,
	input cell_idx_t p1_cor,
	input cell_idx_t p2_cor,
	output occ_code_t [CELL_NUM-1:0] occ_grid,
	output game_result_t result
);

	logic p1_wet;
	logic p2_wet;

	always_comb begin
		for (int i = 0; i < CELL_NUM; i++) begin
			case (cells[i].kind)
				CELL_BOMB: occ_grid[i] = OCC_BOMB;
				CELL_WATER: begin
					case (cells[i].pl.water.dir)
						DIR_CEN: occ_grid[i] = OCC_CEN;
						DIR_UP: occ_grid[i] = OCC_UP;
						DIR_DOWN: occ_grid[i] = OCC_DOWN;
						DIR_LEFT: occ_grid[i] = OCC_LEFT;
						default: occ_grid[i] = OCC_RIGHT;
					endcase
				end
				default: occ_grid[i] = OCC_NONE;
			endcase
		end
	end

	assign p1_wet = (cells[p1_cor].kind == CELL_WATER);
	assign p2_wet = (cells[p2_cor].kind == CELL_WATER);

	// first soaking decides the game, both at once is a draw
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (!result.over && (p1_wet || p2_wet)) begin
			result.over <= 1'b1;
			result.p1_win <= p2_wet;
			result.p2_win <= p1_wet;
		end
	end

	a_win_over: assert property (@(posedge clk) disable iff (!rst_n)
		(result.p1_win || result.p2_win) |-> result.over)
		else $error("win bit without game over");

endmodule

`default_nettype wire

/* verilog/blast_spread.sv */
`timescale 1ns/100ps
`default_nettype none

module blast_spread
	import bomb_grid_pkg::*;
#(
	parameter int FUSE_CYCLES = 60
) (
	input cell_t [CELL_NUM-1:0] cells,
	output wet_map_t wet_map,
	output dir_t [CELL_NUM-1:0] wet_dir
);

	logic [CELL_NUM-1:0] hit_cen;
	logic [CELL_NUM-1:0] hit_up;
	logic [CELL_NUM-1:0] hit_down;
	logic [CELL_NUM-1:0] hit_left;
	logic [CELL_NUM-1:0] hit_right;

	// mark the cross of each bomb whose fuse ends now, clipped at the edges
	always_comb begin
		hit_cen = '0;
		hit_up = '0;
		hit_down = '0;
		hit_left = '0;
		hit_right = '0;
		for (int c = 0; c < CELL_NUM; c++) begin
			if (cells[c].kind == CELL_BOMB && cells[c].pl.bomb.fuse == 7'(FUSE_CYCLES)) begin
				hit_cen[c] = 1'b1;
				for (int d = 1; d <= 4; d++) begin
					if (d <= int'(cells[c].pl.bomb.len) + 1) begin
						if (c / GRID_DIM >= d)
							hit_up[c - d * GRID_DIM] = 1'b1;
						if (c / GRID_DIM + d < GRID_DIM)
							hit_down[c + d * GRID_DIM] = 1'b1;
						if (c % GRID_DIM >= d)
							hit_left[c - d] = 1'b1;
						if (c % GRID_DIM + d < GRID_DIM)
							hit_right[c + d] = 1'b1;
					end
				end
			end
		end
	end

	// overlap priority is center, up, right, down, left
	always_comb begin
		for (int i = 0; i < CELL_NUM; i++) begin
			wet_map[i] = hit_cen[i] | hit_up[i] | hit_down[i] | hit_left[i] | hit_right[i];
			if (hit_cen[i])
				wet_dir[i] = DIR_CEN;
			else if (hit_up[i])
				wet_dir[i] = DIR_UP;
			else if (hit_right[i])
				wet_dir[i] = DIR_RIGHT;
			else if (hit_down[i])
				wet_dir[i] = DIR_DOWN;
			else
				wet_dir[i] = DIR_LEFT; // also the value on dry cells
		end
	end

endmodule

`default_nettype wire

/* verilog/cell_array.sv */
`timescale 1ns/100ps
`default_nettype none

module cell_array
	import bomb_grid_pkg::*;
#(
	parameter int FUSE_CYCLES = 60,
	parameter int WATER_CYCLES = 20
) (
	input wire logic clk,
	input wire logic rst_n,
	input player_req_t p1_req,
	input player_req_t p2_req,
	input wire logic accept1,
	input wire logic accept2,
	input wet_map_t wet_map,
	input dir_t [CELL_NUM-1:0] wet_dir,
	output cell_t [CELL_NUM-1:0] cells,
	output logic [1:0] burst_owner1,
	output logic [1:0] burst_owner2
);

	cell_kind_t [CELL_NUM-1:0] kind_q;
	cell_kind_t [CELL_NUM-1:0] kind_nxt;
	cell_payload_u [CELL_NUM-1:0] pl_q;
	cell_payload_u [CELL_NUM-1:0] pl_nxt;
	logic [CELL_NUM-1:0] burst;

	always_comb begin
		for (int i = 0; i < CELL_NUM; i++) begin
			cells[i].kind = kind_q[i];
			cells[i].pl = pl_q[i];
			burst[i] = (kind_q[i] == CELL_BOMB) && (pl_q[i].bomb.fuse == 7'(FUSE_CYCLES));
		end
	end

	// per-player burst counts for the unburst counters
	always_comb begin
		burst_owner1 = 2'd0;
		burst_owner2 = 2'd0;
		for (int i = 0; i < CELL_NUM; i++) begin
			if (burst[i] && pl_q[i].bomb.owner)
				burst_owner2 = burst_owner2 + 2'd1;
			else if (burst[i])
				burst_owner1 = burst_owner1 + 2'd1;
		end
	end

	always_comb begin
		for (int i = 0; i < CELL_NUM; i++) begin
			kind_nxt[i] = kind_q[i];
			pl_nxt[i] = pl_q[i];
			if (kind_q[i] == CELL_BOMB) begin
				pl_nxt[i].bomb.fuse = pl_q[i].bomb.fuse + 7'd1;
			end else if (kind_q[i] == CELL_WATER) begin
				if (pl_q[i].water.cnt + 7'd1 == 7'(WATER_CYCLES))
					kind_nxt[i] = CELL_EMPTY; // water dries up
				else
					pl_nxt[i].water.cnt = pl_q[i].water.cnt + 7'd1;
			end
			// a bursting bomb counts as gone, other bombs ignore water
			if (wet_map[i] && (kind_q[i] != CELL_BOMB || burst[i])) begin
				kind_nxt[i] = CELL_WATER;
				pl_nxt[i].water.dir = wet_dir[i];
				pl_nxt[i].water.cnt = 7'd0;
			end
			if (accept1 && (p1_req.pos == CELL_W'(i))) begin
				kind_nxt[i] = CELL_BOMB;
				pl_nxt[i].bomb = '{owner: 1'b0, len: p1_req.len, fuse: 7'd1};
			end else if (accept2 && (p2_req.pos == CELL_W'(i))) begin
				kind_nxt[i] = CELL_BOMB;
				pl_nxt[i].bomb = '{owner: 1'b1, len: p2_req.len, fuse: 7'd1};
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < CELL_NUM; i++)
				kind_q[i] <= CELL_EMPTY;
		end else begin
			kind_q <= kind_nxt;
		end
	end

	always_ff @(posedge clk) begin
		pl_q <= pl_nxt; // meaning follows kind_q
	end

	a_accept_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(!accept1 || kind_q[p1_req.pos] == CELL_EMPTY)
		&& (!accept2 || kind_q[p2_req.pos] == CELL_EMPTY))
		else $error("accept on an occupied cell");

endmodule

`default_nettype wire

/* verilog/placement_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module placement_ctrl
	import bomb_grid_pkg::*;
#(
	parameter int BOMB_CAP = 1
) (
	input wire logic clk,
	input wire logic rst_n,
	input player_req_t p1_req,
	input player_req_t p2_req,
	input cell_t [CELL_NUM-1:0] cells,
	input game_result_t result,
	input wire logic [1:0] burst_owner1,
	input wire logic [1:0] burst_owner2,
	output logic accept1,
	output logic accept2,
	output logic [2:0] p1_unburst,
	output logic [2:0] p2_unburst
);

	logic p1_ok;
	logic p2_ok;

	// request is valid only on an empty cell, with free capacity, while in play
	assign p1_ok = p1_req.set && !result.over && (cells[p1_req.pos].kind == CELL_EMPTY)
		&& (p1_unburst < 3'(BOMB_CAP));
	assign p2_ok = p2_req.set && !result.over && (cells[p2_req.pos].kind == CELL_EMPTY)
		&& (p2_unburst < 3'(BOMB_CAP));

	assign accept1 = p1_ok;
	assign accept2 = p2_ok && !(p1_ok && (p1_req.pos == p2_req.pos)); // p1 wins a tie

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p1_unburst <= 3'd0;
			p2_unburst <= 3'd0;
		end else begin
			// place and burst may land on the same edge
			p1_unburst <= p1_unburst + {2'b00, accept1} - {1'b0, burst_owner1};
			p2_unburst <= p2_unburst + {2'b00, accept2} - {1'b0, burst_owner2};
		end
	end

	a_cap_held: assert property (@(posedge clk) disable iff (!rst_n)
		(p1_unburst <= 3'(BOMB_CAP)) && (p2_unburst <= 3'(BOMB_CAP)))
		else $error("unburst count above capacity");

endmodule

`default_nettype wire

/* verilog/bomb_grid_pkg.sv */
`default_nettype none

package bomb_grid_pkg;

	localparam int GRID_DIM = 16; // board side
	localparam int CELL_NUM = 256; // GRID_DIM * GRID_DIM
	localparam int CELL_W = 8; // index = row * GRID_DIM + col

	typedef logic [CELL_W-1:0] cell_idx_t;
	typedef logic [1:0] blast_len_t; // arm length minus one

	typedef enum logic [2:0] {
		DIR_UP = 3'd0,
		DIR_DOWN = 3'd1,
		DIR_LEFT = 3'd2,
		DIR_RIGHT = 3'd3,
		DIR_CEN = 3'd4
	} dir_t;

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_BOMB = 2'd1,
		CELL_WATER = 2'd2
	} cell_kind_t;

	typedef struct packed {
		logic owner; // 0 p1, 1 p2
		blast_len_t len;
		logic [6:0] fuse;
	} bomb_view_t;

	typedef struct packed {
		dir_t dir;
		logic [6:0] cnt;
	} water_view_t;

	// one payload word, read according to the cell kind
	typedef union packed {
		bomb_view_t bomb;
		water_view_t water;
	} cell_payload_u;

	typedef struct packed {
		cell_kind_t kind;
		cell_payload_u pl;
	} cell_t;

	typedef struct packed {
		logic set; // one-cycle place strobe
		cell_idx_t pos;
		blast_len_t len;
	} player_req_t;

	typedef enum logic [3:0] {
		OCC_NONE = 4'd0,
		OCC_BOMB = 4'd1,
		OCC_CEN = 4'd2,
		OCC_UP = 4'd3,
		OCC_DOWN = 4'd4,
		OCC_LEFT = 4'd5,
		OCC_RIGHT = 4'd6
	} occ_code_t;

	typedef struct packed {
		logic over;
		logic p1_win;
		logic p2_win;
	} game_result_t;

	typedef logic [CELL_NUM-1:0] wet_map_t;

endpackage

`default_nettype wire
